// ==== vlog.f ====
+incdir+include
design/rv_pkg.sv
design/decouple_if.sv
design/inst_decoder.sv
design/reg_file.sv
design/csr_file.sv
design/alu.sv
design/exec_ctrl.sv
design/exec_top.sv
verification/exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  -f vlog.f --top-module exec_tb -o exec_sim

out=$(./obj_dir/exec_sim 2>&1) || true
echo "$out"

if grep -q "RESULT: PASS" <<< "$out"; then
  exit 0
fi
exit 1

// ==== verification/exec_tb.sv ====
`timescale 1ns/100ps

module exec_tb;

  localparam int WAIT_LIMIT = 50; // cycles per wait before giving up

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic [4:0] rd;
    logic [31:0] result;
    logic [31:0] csr_old;
    logic taken;
  } row_t;

  logic clk;
  logic arst_n;
  logic in_valid;
  logic in_ready;
  logic [31:0] in_inst;
  logic [31:0] in_pc;
  logic out_valid;
  logic out_ready;
  logic [31:0] out_pc;
  logic [4:0] out_rd;
  logic [31:0] out_result;
  logic [31:0] out_csr_old;
  logic out_branch_taken;

  row_t rows[$];
  integer seed = 32'h2249_5795;

  exec_top dut0 (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
    .in_inst(in_inst), .in_pc(in_pc), .out_valid(out_valid), .out_ready(out_ready),
    .out_pc(out_pc), .out_rd(out_rd), .out_result(out_result),
    .out_csr_old(out_csr_old), .out_branch_taken(out_branch_taken)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic timed_out(input string what);
    $display("timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
    abort_run();
  endtask

  task automatic add_row(input logic [31:0] inst, input logic [31:0] pc, input logic [4:0] rd,
                         input logic [31:0] result, input logic [31:0] csr_old,
                         input logic taken);
    row_t r;
    r.inst = inst;
    r.pc = pc;
    r.rd = rd;
    r.result = result;
    r.csr_old = csr_old;
    r.taken = taken;
    rows.push_back(r);
  endtask

  // inst, pc, rd, result, csr_old, taken
  task automatic load_table();
    add_row(32'h0050_0093, 32'h100, 5'd1, 32'h0000_0005, 32'h0, 1'b0); // addi x1, x0, 5
    add_row(32'hFFD0_0113, 32'h104, 5'd2, 32'hFFFF_FFFD, 32'h0, 1'b0); // addi x2, x0, -3
    add_row(32'h0F00_C193, 32'h108, 5'd3, 32'h0000_00F5, 32'h0, 1'b0); // xori x3, x1, 0xf0
    add_row(32'h0011_2213, 32'h10C, 5'd4, 32'h0000_0001, 32'h0, 1'b0); // slti x4, x2, 1
    add_row(32'h4011_5293, 32'h110, 5'd5, 32'hFFFF_FFFE, 32'h0, 1'b0); // srai x5, x2, 1
    add_row(32'h0030_8333, 32'h114, 5'd6, 32'h0000_00FA, 32'h0, 1'b0); // add x6, x1, x3
    add_row(32'h4020_83B3, 32'h118, 5'd7, 32'h0000_0008, 32'h0, 1'b0); // sub x7, x1, x2
    add_row(32'h0040_9433, 32'h11C, 5'd8, 32'h0000_000A, 32'h0, 1'b0); // sll x8, x1, x4
    add_row(32'h0020_B4B3, 32'h120, 5'd9, 32'h0000_0001, 32'h0, 1'b0); // sltu x9, x1, x2
    add_row(32'h4041_5533, 32'h124, 5'd10, 32'hFFFF_FFFE, 32'h0, 1'b0); // sra x10, x2, x4
    add_row(32'h0010_8033, 32'h128, 5'd0, 32'h0000_000A, 32'h0, 1'b0); // add x0, x1, x1
    add_row(32'h0000_05B3, 32'h12C, 5'd11, 32'h0000_0000, 32'h0, 1'b0); // x0 still zero
    add_row(32'h1234_5637, 32'h130, 5'd12, 32'h1234_5000, 32'h0, 1'b0); // lui
    add_row(32'h0000_1697, 32'h134, 5'd13, 32'h0000_1134, 32'h0, 1'b0); // auipc +0x1000
    add_row(32'h0080_076F, 32'h138, 5'd14, 32'h0000_013C, 32'h0, 1'b0); // jal x14, +8
    add_row(32'h0000_87E7, 32'h13C, 5'd15, 32'h0000_0140, 32'h0, 1'b0); // jalr x15, x1
    // branches use offset 16 so the rd field reads 16
    add_row(32'h0060_8863, 32'h140, 5'd16, 32'h0000_00FF, 32'h0, 1'b0); // beq x1, x6
    add_row(32'h0010_8863, 32'h144, 5'd16, 32'h0000_0000, 32'h0, 1'b1); // beq x1, x1
    add_row(32'h0060_9863, 32'h148, 5'd16, 32'h0000_00FF, 32'h0, 1'b1); // bne x1, x6
    add_row(32'h0011_4863, 32'h14C, 5'd16, 32'h0000_0001, 32'h0, 1'b1); // blt x2, x1
    add_row(32'h0011_5863, 32'h150, 5'd16, 32'h0000_0001, 32'h0, 1'b0); // bge x2, x1
    add_row(32'h0011_6863, 32'h154, 5'd16, 32'h0000_0000, 32'h0, 1'b0); // bltu x2, x1
    add_row(32'h0011_7863, 32'h158, 5'd16, 32'h0000_0000, 32'h0, 1'b1); // bgeu x2, x1
    add_row(32'h0008_08B3, 32'h15C, 5'd17, 32'h0000_0000, 32'h0, 1'b0); // x16 never written
    add_row(32'h3403_1973, 32'h160, 5'd18, 32'h0, 32'h0, 1'b0); // csrrw mscratch, x6
    add_row(32'h3400_A9F3, 32'h164, 5'd19, 32'hFA, 32'hFA, 1'b0); // csrrs mscratch, x1
    add_row(32'h3401_BA73, 32'h168, 5'd20, 32'hFF, 32'hFF, 1'b0); // csrrc mscratch, x3
    add_row(32'h3400_2AF3, 32'h16C, 5'd21, 32'h0A, 32'h0A, 1'b0); // read back mscratch
    add_row(32'h305F_DB73, 32'h170, 5'd22, 32'h0, 32'h0, 1'b0); // csrrwi mtvec, 0x1f
    add_row(32'h341A_6BF3, 32'h174, 5'd23, 32'h0, 32'h0, 1'b0); // csrrsi mepc, 0x14
    add_row(32'h3051_FC73, 32'h178, 5'd24, 32'h1F, 32'h1F, 1'b0); // csrrci mtvec, 3
    add_row(32'h3050_2CF3, 32'h17C, 5'd25, 32'h1C, 32'h1C, 1'b0); // read back mtvec
    add_row(32'h3410_2D73, 32'h180, 5'd26, 32'h14, 32'h14, 1'b0); // read back mepc
    add_row(32'h000A_0DB3, 32'h184, 5'd27, 32'hFF, 32'h0, 1'b0); // add x27, x20, x0
  endtask

  function automatic int stall_count(input int idx);
    int n;
    n = $unsigned($random(seed)) % 4;
    if (idx % 8 == 0) n = 5; // a long stall now and then
    return n;
  endfunction

  task automatic check_output(input row_t r);
    compare("out_valid", 32'(out_valid), 32'd1);
    compare("out_pc", out_pc, r.pc);
    compare("out_rd", 32'(out_rd), 32'(r.rd));
    compare("out_result", out_result, r.result);
    compare("out_csr_old", out_csr_old, r.csr_old);
    compare("out_branch_taken", 32'(out_branch_taken), 32'(r.taken));
  endtask

  // payload must hold and in_ready stay low until out_ready rises
  task automatic hold_and_release(input row_t r, input int stalls);
    check_output(r);
    for (int k = 0; k < stalls; k++) begin
      @(negedge clk);
      check_output(r);
      compare("in_ready", 32'(in_ready), 32'd0);
    end
    out_ready = 1'b1;
  endtask

  task automatic wait_accept();
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (!in_ready) begin
      cnt++;
      if (cnt > WAIT_LIMIT) timed_out("in_ready");
      @(posedge clk);
    end
  endtask

  task automatic wait_out_valid();
    int cnt;
    cnt = 0;
    while (!out_valid) begin
      @(negedge clk);
      cnt++;
      if (cnt > WAIT_LIMIT) timed_out("out_valid");
    end
  endtask

  initial begin
    clk = 1'b0;
    arst_n = 1'b0;
    in_valid = 1'b0;
    in_inst = '0;
    in_pc = '0;
    out_ready = 1'b0;
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    compare("out_valid", 32'(out_valid), 32'd0);
    for (int i = 0; i < rows.size(); i++) begin
      in_valid = 1'b1; // next inst waits while the previous result stalls
      in_inst = rows[i].inst;
      in_pc = rows[i].pc;
      if (i > 0) hold_and_release(rows[i-1], stall_count(i));
      wait_accept();
      @(negedge clk);
      out_ready = 1'b0;
      wait_out_valid();
    end
    in_valid = 1'b0;
    hold_and_release(rows[rows.size()-1], stall_count(rows.size()));
    @(negedge clk);
    out_ready = 1'b0;
    compare("out_valid", 32'(out_valid), 32'd0); // last result produced once only
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== design/exec_top.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module exec_top import rv_pkg::*; (
  input logic clk,
  input logic arst_n,
  input logic in_valid,
  output logic in_ready,
  input logic [31:0] in_inst,
  input logic [`XLEN-1:0] in_pc,
  output logic out_valid,
  input logic out_ready,
  output logic [`XLEN-1:0] out_pc,
  output logic [4:0] out_rd,
  output logic [`XLEN-1:0] out_result,
  output logic [`XLEN-1:0] out_csr_old,
  output logic out_branch_taken
);

  decouple_if #(.payload_t(inst_pkt_t)) inst_ch ();
  decouple_if #(.payload_t(result_pkt_t)) res_ch ();

  logic [4:0] reg_raddr1;
  logic [4:0] reg_raddr2;
  logic [`XLEN-1:0] reg_rdata1;
  logic [`XLEN-1:0] reg_rdata2;
  logic [11:0] csr_raddr;
  logic [`XLEN-1:0] csr_rdata;
  logic [`XLEN-1:0] alu_a;
  logic [`XLEN-1:0] alu_b;
  alu_funct_e alu_funct;
  logic alu_funcs;
  logic [`XLEN-1:0] alu_y;
  opcode_e opcode;
  logic [2:0] funct;
  logic [4:0] rd;
  logic [`XLEN-1:0] csr;
  logic reg_we;
  logic csr_we;
  logic [11:0] csr_waddr;
  logic [`XLEN-1:0] wdata;
  logic [`XLEN-1:0] csr_wdata;

  // flatten the channels onto plain ports
  assign inst_ch.valid = in_valid;
  assign inst_ch.payload.inst = in_inst;
  assign inst_ch.payload.pc = in_pc;
  assign in_ready = inst_ch.ready;

  assign out_valid = res_ch.valid;
  assign res_ch.ready = out_ready;
  assign out_pc = res_ch.payload.pc;
  assign out_rd = res_ch.payload.rd;
  assign out_result = res_ch.payload.result;
  assign out_csr_old = res_ch.payload.csr_old;
  assign out_branch_taken = res_ch.payload.branch_taken;

  inst_decoder u_decoder (
    .inst_ch(inst_ch), .reg_raddr1(reg_raddr1), .reg_raddr2(reg_raddr2),
    .reg_rdata1(reg_rdata1), .reg_rdata2(reg_rdata2), .csr_raddr(csr_raddr),
    .csr_rdata(csr_rdata), .alu_a(alu_a), .alu_b(alu_b), .alu_funct(alu_funct),
    .alu_funcs(alu_funcs), .opcode(opcode), .funct(funct), .rd(rd),
    .src1(), .src2(), .csr(csr)
  );

  reg_file u_reg_file (
    .clk(clk), .arst_n(arst_n), .raddr1(reg_raddr1), .raddr2(reg_raddr2),
    .rdata1(reg_rdata1), .rdata2(reg_rdata2), .we(reg_we), .waddr(rd),
    .wdata(wdata)
  );

  csr_file u_csr_file (
    .clk(clk), .arst_n(arst_n), .raddr(csr_raddr), .rdata(csr_rdata),
    .we(csr_we), .waddr(csr_waddr), .wdata(csr_wdata)
  );

  alu u_alu (.a(alu_a), .b(alu_b), .funct(alu_funct), .funcs(alu_funcs), .y(alu_y));

  exec_ctrl u_ctrl (
    .clk(clk), .arst_n(arst_n), .inst_ch(inst_ch), .res_ch(res_ch),
    .opcode(opcode), .funct(funct), .rd(rd), .csr(csr), .alu_y(alu_y),
    .reg_we(reg_we), .csr_we(csr_we), .csr_waddr(csr_waddr), .wdata(wdata),
    .csr_wdata(csr_wdata)
  );

endmodule

// ==== design/exec_ctrl.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module exec_ctrl import rv_pkg::*; (
  input logic clk,
  input logic arst_n,
  decouple_if.in inst_ch,
  decouple_if.out res_ch,
  input opcode_e opcode,
  input logic [2:0] funct,
  input logic [4:0] rd,
  input logic [`XLEN-1:0] csr,
  input logic [`XLEN-1:0] alu_y,
  output logic reg_we,
  output logic csr_we,
  output logic [11:0] csr_waddr,
  output logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0] csr_wdata
);

  logic accept;
  logic csr_op;
  logic no_rd; // opcodes without a register result
  logic taken;

  // one in flight, pass-through when the sink drains
  assign inst_ch.ready = !res_ch.valid || res_ch.ready;
  assign accept = inst_ch.valid && inst_ch.ready;

  assign csr_op = (opcode == OP_SYS) && (funct != 3'd0);
  assign no_rd = (opcode == OP_BRANCH) || (opcode == OP_STORE) ||
                 (opcode == OP_LOAD) || (opcode == OP_SYS && funct == 3'd0);

  assign reg_we = accept && !no_rd;
  assign csr_we = accept && csr_op;
  assign csr_waddr = inst_ch.payload.inst[31:20];
  assign wdata = csr_op ? csr : alu_y; // csr ops return the old value
  assign csr_wdata = alu_y;

  // funct[2] picks the compare bit, funct[0] inverts
  assign taken = (opcode == OP_BRANCH) &&
                 ((funct[2] ? alu_y[0] : (alu_y == '0)) ^ funct[0]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_ch.valid <= 1'b0;
    end else if (accept) begin
      res_ch.valid <= 1'b1;
    end else if (res_ch.ready) begin
      res_ch.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_ch.payload.pc <= inst_ch.payload.pc;
      res_ch.payload.rd <= rd;
      res_ch.payload.result <= wdata;
      res_ch.payload.csr_old <= csr_op ? csr : '0;
      res_ch.payload.branch_taken <= taken;
    end
  end

  a_hold_valid: assert property (@(posedge clk) disable iff (!arst_n)
    res_ch.valid && !res_ch.ready |=> res_ch.valid);

  a_hold_payload: assert property (@(posedge clk) disable iff (!arst_n)
    res_ch.valid && !res_ch.ready |=> $stable(res_ch.payload));

endmodule

// ==== design/alu.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module alu import rv_pkg::*; (
  input logic [`XLEN-1:0] a,
  input logic [`XLEN-1:0] b,
  input alu_funct_e funct,
  input logic funcs,
  output logic [`XLEN-1:0] y
);

  logic [4:0] shamt;

  assign shamt = b[4:0];

  always_comb begin
    case (funct)
      ALU_ADD: y = funcs ? a - b : a + b;
      ALU_SHL: y = a << shamt;
      ALU_LTS: y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      ALU_LTU: y = {{(`XLEN-1){1'b0}}, a < b};
      ALU_XOR: y = a ^ b;
      ALU_SHR: begin
        if (funcs) y = $unsigned($signed(a) >>> shamt); // sra
        else y = a >> shamt;
      end
      ALU_OR: y = a | b;
      // inverted b gives csr clear
      ALU_AND: y = a & (funcs ? ~b : b);
      default: y = '0;
    endcase
  end

endmodule

// ==== design/csr_file.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module csr_file (
  input logic clk,
  input logic arst_n,
  input logic [11:0] raddr,
  output logic [`XLEN-1:0] rdata,
  input logic we,
  input logic [11:0] waddr,
  input logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] mscratch;
  logic [`XLEN-1:0] mtvec;
  logic [`XLEN-1:0] mepc;

  always_comb begin
    case (raddr)
      `CSR_MSCRATCH: rdata = mscratch;
      `CSR_MTVEC: rdata = mtvec;
      `CSR_MEPC: rdata = mepc;
      default: rdata = '0; // unimplemented csr
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mscratch <= '0;
      mtvec <= '0;
      mepc <= '0;
    end else if (we) begin
      case (waddr)
        `CSR_MSCRATCH: mscratch <= wdata;
        `CSR_MTVEC: mtvec <= wdata;
        `CSR_MEPC: mepc <= wdata;
        default: ; // write dropped
      endcase
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module reg_file (
  input logic clk,
  input logic arst_n,
  input logic [4:0] raddr1,
  input logic [4:0] raddr2,
  output logic [`XLEN-1:0] rdata1,
  output logic [`XLEN-1:0] rdata2,
  input logic we,
  input logic [4:0] waddr,
  input logic [`XLEN-1:0] wdata
);

  logic [`XLEN-1:0] regs [`REG_NUM];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `REG_NUM; i++) regs[i] <= '0;
    end else if (we && waddr != 5'd0) begin // x0 stays hardwired
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // x0 reads zero whatever was written before
  a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (raddr1 == 5'd0 |-> rdata1 == '0) and (raddr2 == 5'd0 |-> rdata2 == '0));

endmodule

// ==== design/inst_decoder.sv ====
`timescale 1ns/100ps
`include "rv_defines.svh"

module inst_decoder import rv_pkg::*; (
  decouple_if.in inst_ch,
  output logic [4:0] reg_raddr1,
  output logic [4:0] reg_raddr2,
  input logic [`XLEN-1:0] reg_rdata1,
  input logic [`XLEN-1:0] reg_rdata2,
  output logic [11:0] csr_raddr,
  input logic [`XLEN-1:0] csr_rdata,
  output logic [`XLEN-1:0] alu_a,
  output logic [`XLEN-1:0] alu_b,
  output alu_funct_e alu_funct,
  output logic alu_funcs,
  output opcode_e opcode,
  output logic [2:0] funct,
  output logic [4:0] rd,
  output logic [`XLEN-1:0] src1,
  output logic [`XLEN-1:0] src2,
  output logic [`XLEN-1:0] csr
);

  logic [31:0] inst;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] imm;
  logic [`XLEN-1:0] zimm;
  logic funcs_en;

  assign inst = inst_ch.payload.inst;
  assign pc = inst_ch.payload.pc;

  assign opcode = opcode_e'(inst[6:2]);
  assign funct = inst[14:12];
  assign rd = inst[11:7];

  // register reads are combinational
  assign reg_raddr1 = inst[19:15];
  assign reg_raddr2 = inst[24:20];
  assign src1 = reg_rdata1;
  assign src2 = reg_rdata2;

  assign csr_raddr = inst[31:20];
  assign csr = csr_rdata;
  assign zimm = {27'b0, inst[19:15]}; // rs1 field as unsigned imm

  always_comb begin
    case (opcode)
      OP_CALRI, OP_LOAD, OP_JALR, OP_SYS: imm = {{20{inst[31]}}, inst[31:20]};
      OP_STORE: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      OP_BRANCH: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {inst[31:12], 12'b0};
      OP_JAL: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0; // register-register, no imm
    endcase
  end

  always_comb begin
    case (opcode)
      OP_LOAD, OP_STORE, OP_CALRI, OP_CALRR, OP_BRANCH: alu_a = src1;
      OP_AUIPC, OP_JAL, OP_JALR: alu_a = pc;
      OP_SYS: begin
        // csrrw just passes rs1/zimm through
        if (funct == CSRF_RW || funct == CSRF_RWI) alu_a = '0;
        else alu_a = csr;
      end
      default: alu_a = '0; // lui
    endcase
  end

  always_comb begin
    case (opcode)
      OP_CALRR, OP_BRANCH: alu_b = src2;
      OP_LUI, OP_AUIPC, OP_LOAD, OP_STORE, OP_CALRI: alu_b = imm;
      OP_SYS: alu_b = funct[2] ? zimm : src1;
      default: alu_b = `XLEN'd4; // link value pc+4
    endcase
  end

  always_comb begin
    case (opcode)
      OP_CALRI, OP_CALRR: alu_funct = alu_funct_e'(funct);
      OP_BRANCH: begin
        case (funct)
          BR_BLT, BR_BGE: alu_funct = ALU_LTS;
          BR_BLTU, BR_BGEU: alu_funct = ALU_LTU;
          default: alu_funct = ALU_XOR; // beq/bne test for zero
        endcase
      end
      OP_SYS: begin
        case (funct)
          CSRF_RS, CSRF_RSI: alu_funct = ALU_OR;
          CSRF_RC, CSRF_RCI: alu_funct = ALU_AND;
          default: alu_funct = ALU_XOR;
        endcase
      end
      default: alu_funct = ALU_ADD;
    endcase
  end

  // bit 30 only selects sub/sra for R-type and srai for I-type
  assign funcs_en = (opcode == OP_CALRR) ||
                    (opcode == OP_CALRI && funct == ALU_SHR);
  // csrrc/csrrci have both low funct bits set
  assign alu_funcs = (inst[30] & funcs_en) |
                     ((opcode == OP_SYS) & funct[1] & funct[0]);

endmodule

// ==== design/decouple_if.sv ====
`timescale 1ns/100ps

interface decouple_if #(
  parameter type payload_t = logic
);

  logic valid;
  logic ready;
  payload_t payload; // held while valid && !ready

  // consumer side
  modport in (input valid, input payload, output ready);

  // producer side
  modport out (output valid, output payload, input ready);

endinterface

// ==== design/rv_pkg.sv ====
`include "rv_defines.svh"

package rv_pkg;

  // inst[6:2]
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_CALRI  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_CALRR  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011,
    OP_SYS    = 5'b11100
  } opcode_e;

  // same codes as the RV funct3 of OP/OP-IMM
  typedef enum logic [2:0] {
    ALU_ADD = 3'b000,
    ALU_SHL = 3'b001,
    ALU_LTS = 3'b010,
    ALU_LTU = 3'b011,
    ALU_XOR = 3'b100,
    ALU_SHR = 3'b101,
    ALU_OR  = 3'b110,
    ALU_AND = 3'b111
  } alu_funct_e;

  typedef enum logic [2:0] {
    CSRF_RW  = 3'b001,
    CSRF_RS  = 3'b010,
    CSRF_RC  = 3'b011,
    CSRF_RWI = 3'b101,
    CSRF_RSI = 3'b110,
    CSRF_RCI = 3'b111
  } csr_funct_e;

  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_funct_e;

  typedef struct packed {
    logic [31:0] inst;
    logic [`XLEN-1:0] pc;
  } inst_pkt_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0] rd;
    logic [`XLEN-1:0] result;
    logic [`XLEN-1:0] csr_old; // zero unless a CSR op
    logic branch_taken;
  } result_pkt_t;

endpackage

// ==== include/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path width
`define XLEN 32

// integer register count, x0 included
`define REG_NUM 32

// machine CSR addresses
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC 12'h305
`define CSR_MEPC 12'h341

`endif
